//--- list.f
+incdir+include
source/vc_switch_pkg.sv
source/fifo_ram.sv
source/vc_fifo.sv
source/vc_dispatch.sv
source/vc_egress_arbiter.sv
source/vc_switch_top.sv
tests/vc_switch_props.sv
tests/vc_switch_check.sv
tests/vc_switch_tb.sv

//--- Bender.yml
package:
  name: vc_switch

sources:
  - include_dirs:
      - include
    files:
      - source/vc_switch_pkg.sv
      - source/fifo_ram.sv
      - source/vc_fifo.sv
      - source/vc_dispatch.sv
      - source/vc_egress_arbiter.sv
      - source/vc_switch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/vc_switch_props.sv
      - tests/vc_switch_check.sv
      - tests/vc_switch_tb.sv

//--- tests/vc_switch_tb.sv
`timescale 1ns/100ps

`include "vc_switch_params.svh"

module vc_switch_tb;

    localparam logic [31:0] SEED = 32'h009e_e3d3;
    localparam int ITEMS = 400;
    localparam int FILL_TRIES = 40;
    localparam int CYCLE_LIMIT = ITEMS * 20 + 100;    // margin for reset and phase gaps

    logic                      clk;
    logic                      reset_L;
    logic                      push;
    vc_switch_pkg::data_t      data_in;
    vc_switch_pkg::threshold_t af_threshold;
    logic                      pop_d0;
    logic                      pop_d1;
    vc_switch_pkg::data_t      data_d0;
    vc_switch_pkg::data_t      data_d1;
    logic                      empty_d0;
    logic                      empty_d1;
    logic                      pause_in;
    logic                      error;
    logic                      fill_mode;
    logic                      end_check;
    int                        data_errors;
    int                        flag_errors;
    int                        assert_fails;
    int                        cycles = 0;
    int                        sent;
    int                        popped;
    int                        fill_accepted;

    vc_switch_top UUT (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (push),
        .data_in      (data_in),
        .af_threshold (af_threshold),
        .pop_d0       (pop_d0),
        .pop_d1       (pop_d1),
        .data_d0      (data_d0),
        .data_d1      (data_d1),
        .empty_d0     (empty_d0),
        .empty_d1     (empty_d1),
        .pause_in     (pause_in),
        .error        (error)
    );

    vc_switch_check u_check (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (push),
        .data_in      (data_in),
        .af_threshold (af_threshold),
        .pop_d0       (pop_d0),
        .pop_d1       (pop_d1),
        .data_d0      (data_d0),
        .data_d1      (data_d1),
        .empty_d0     (empty_d0),
        .empty_d1     (empty_d1),
        .pause_in     (pause_in),
        .error        (error),
        .fill_mode    (fill_mode),
        .end_check    (end_check),
        .data_errors  (data_errors),
        .flag_errors  (flag_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic vc_switch_pkg::threshold_t pick_threshold();
        return vc_switch_pkg::threshold_t'(3 + $urandom % 4);
    endfunction

    // at most one pop per two cycles, so a queue seen non-empty stays so
    task automatic random_pops();
        if (!empty_d0 && !pop_d0 && ($urandom % 2 == 0)) begin
            pop_d0 <= 1'b1;
            popped++;
        end else begin
            pop_d0 <= 1'b0;
        end
        if (!empty_d1 && !pop_d1 && ($urandom % 2 == 0)) begin
            pop_d1 <= 1'b1;
            popped++;
        end else begin
            pop_d1 <= 1'b0;
        end
    endtask

    task automatic push_traffic(input int items);
        sent = 0;
        popped = 0;
        while (sent < items) begin
            @(posedge clk);
            if (!pause_in && ($urandom % 4 != 0)) begin
                push <= 1'b1;
                data_in <= vc_switch_pkg::data_t'($urandom);
                sent++;
            end else begin
                push <= 1'b0;
            end
            random_pops();
        end
        @(posedge clk);
        push <= 1'b0;
        random_pops();
    endtask

    task automatic drain_switch(input int target);
        while (popped < target) begin
            @(posedge clk);
            random_pops();
        end
        @(posedge clk);
        pop_d0 <= 1'b0;
        pop_d1 <= 1'b0;
        @(posedge clk);     // last word reaches the checker here
    endtask

    task automatic pulse_end_check();
        end_check <= 1'b1;
        @(posedge clk);
        end_check <= 1'b0;
    endtask

    // one class and destination, pushed slowly so the pipeline settles before the input fills
    task automatic fill_switch();
        vc_switch_pkg::data_t word;
        logic                 fill_vc;
        logic                 fill_dest;
        fill_vc = ($urandom % 2) == 1;
        fill_dest = ($urandom % 2) == 1;
        fill_accepted = 0;
        af_threshold <= pick_threshold();
        fill_mode <= 1'b1;
        repeat (FILL_TRIES) begin
            word = vc_switch_pkg::data_t'($urandom);
            word[`VC_BIT] = fill_vc;
            word[`DEST_BIT] = fill_dest;
            @(posedge clk);
            push <= 1'b1;
            data_in <= word;
            @(posedge clk);
            push <= 1'b0;
            if (!error) begin
                fill_accepted++;    // dropped words raise error
            end
            repeat (2) @(posedge clk);
        end
        fill_mode <= 1'b0;
        popped = 0;
    endtask

    task automatic pop_empty_outputs();
        pop_d0 <= 1'b1;
        pop_d1 <= 1'b1;
        @(posedge clk);
        pop_d0 <= 1'b0;
        pop_d1 <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        reset_L = 1'b0;
        push = 1'b0;
        data_in = '0;
        af_threshold = vc_switch_pkg::threshold_t'(6);
        pop_d0 = 1'b0;
        pop_d1 = 1'b0;
        fill_mode = 1'b0;
        end_check = 1'b0;
        repeat (5) @(posedge clk);
        reset_L <= 1'b1;
        af_threshold <= pick_threshold();

        push_traffic(ITEMS);
        drain_switch(ITEMS);
        pulse_end_check();
        fill_switch();
        drain_switch(fill_accepted);
        pulse_end_check();
        pop_empty_outputs();

        assert_fails = UUT.u_in_fifo.u_props.fail_count + UUT.u_vc0_fifo.u_props.fail_count
            + UUT.u_vc1_fifo.u_props.fail_count + UUT.u_d0_fifo.u_props.fail_count
            + UUT.u_d1_fifo.u_props.fail_count;
        $display("errors: %0d data, %0d flag, %0d assertion", data_errors, flag_errors,
                 assert_fails);
        if (data_errors + flag_errors + assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/vc_switch_check.sv
`timescale 1ns/100ps

`include "vc_switch_params.svh"

module vc_switch_check (
    input  logic                        clk,
    input  logic                        reset_L,
    input  logic                        push,
    input  vc_switch_pkg::data_t        data_in,
    input  vc_switch_pkg::threshold_t   af_threshold,
    input  logic                        pop_d0,
    input  logic                        pop_d1,
    input  vc_switch_pkg::data_t        data_d0,
    input  vc_switch_pkg::data_t        data_d1,
    input  logic                        empty_d0,
    input  logic                        empty_d1,
    input  logic                        pause_in,
    input  logic                        error,
    input  logic                        fill_mode,
    input  logic                        end_check,
    output int                          data_errors,
    output int                          flag_errors
);

    localparam int IN_DEPTH = 1 << `MAIN_ADDR_BITS;
    localparam int PAUSE_LIMIT = 32;

    vc_switch_pkg::data_t model_q [4][$];   // index is class * 2 + destination
    vc_switch_pkg::data_t held [2];         // data seen at a pop of an empty queue
    int   dest_count [2];
    int   total;
    int   fill_accepted;
    logic popped [2];                       // word due on data_dN next cycle
    logic empty_popped [2];
    logic reset_seen;
    logic pause_seen;
    logic fill_mode_d;

    task automatic check_word(input int d, input vc_switch_pkg::data_t word);
        int idx;
        idx = int'(word[`VC_BIT]) * 2 + d;
        if (int'(word[`DEST_BIT]) != d) begin
            $display("FAIL %0t: word %h left destination %0d", $time, word, d);
            data_errors++;
        end
        if (model_q[idx].size() == 0) begin
            $display("FAIL %0t: destination %0d gave %h, nothing of that class queued",
                     $time, d, word);
            data_errors++;
        end else begin
            if (word !== model_q[idx][0]) begin
                $display("FAIL %0t: destination %0d gave %h, expected %h",
                         $time, d, word, model_q[idx][0]);
                data_errors++;
            end
            void'(model_q[idx].pop_front());
        end
    endtask

    always @(posedge clk) begin : model
        logic [1:0]           pops;
        logic                 drop;
        logic                 exp_error;
        int                   capacity;
        vc_switch_pkg::data_t now_data;
        if (!reset_L) begin
            for (int i = 0; i < 4; i++) begin
                model_q[i].delete();
            end
            dest_count    = '{0, 0};
            popped        = '{1'b0, 1'b0};
            empty_popped  = '{1'b0, 1'b0};
            total         = 0;
            fill_accepted = 0;
            reset_seen    = 1'b0;
            pause_seen    = 1'b0;
            fill_mode_d   = 1'b0;
            data_errors   = 0;
            flag_errors   = 0;
        end else begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (!empty_d0 || !empty_d1 || pause_in || error) begin
                    $display("FAIL %0t: after reset empty %b%b pause_in %b error %b",
                             $time, empty_d1, empty_d0, pause_in, error);
                    flag_errors++;
                end
            end
            for (int d = 0; d < 2; d++) begin
                now_data = d ? data_d1 : data_d0;
                if (popped[d]) begin
                    check_word(d, now_data);
                end
                if (empty_popped[d] && now_data !== held[d]) begin
                    $display("FAIL %0t: empty pop changed data_d%0d to %h", $time, d, now_data);
                    data_errors++;
                end
            end
            if (fill_mode && !fill_mode_d) begin
                fill_accepted = 0;
                pause_seen    = 1'b0;
            end
            // stalled switch holds the input queue, two held words and the af levels
            capacity  = IN_DEPTH + 2 + 2 * int'(af_threshold);
            pops      = {pop_d1, pop_d0};
            drop      = push && fill_mode && total >= capacity;
            exp_error = (pop_d0 && dest_count[0] == 0) || (pop_d1 && dest_count[1] == 0) || drop;
            if (error !== exp_error) begin
                $display("FAIL %0t: error is %b, expected %b", $time, error, exp_error);
                flag_errors++;
            end
            for (int d = 0; d < 2; d++) begin
                empty_popped[d] = pops[d] && dest_count[d] == 0;
                popped[d]       = pops[d] && dest_count[d] != 0;
                held[d]         = d ? data_d1 : data_d0;
                if (popped[d]) begin
                    dest_count[d]--;
                    total--;
                end
            end
            if (push && !drop) begin
                model_q[int'(data_in[`VC_BIT]) * 2 + int'(data_in[`DEST_BIT])].push_back(data_in);
                dest_count[int'(data_in[`DEST_BIT])]++;
                total++;
                if (fill_mode) begin
                    fill_accepted++;
                end
            end
            if (fill_mode && pause_in && !pause_seen) begin
                pause_seen = 1'b1;
                if (fill_accepted >= PAUSE_LIMIT) begin
                    $display("FAIL %0t: pause_in rose after %0d words", $time, fill_accepted);
                    flag_errors++;
                end
            end
            if (!fill_mode && fill_mode_d && !pause_seen) begin
                $display("pause_in never rose while the switch was being filled");
                flag_errors++;
            end
            fill_mode_d = fill_mode;
            if (end_check) begin
                if (total != 0) begin
                    $display("%0d pushed words were never popped", total);
                    data_errors++;
                end
                if (!empty_d0 || !empty_d1) begin
                    $display("FAIL %0t: drained switch shows empty %b%b",
                             $time, empty_d1, empty_d0);
                    flag_errors++;
                end
            end
        end
    end

endmodule

//--- tests/vc_switch_props.sv
`timescale 1ns/100ps

module vc_switch_props (
    input logic                       clk,
    input logic                       reset_L,
    input logic                       push,
    input logic                       pop,
    input logic                       full,
    input logic                       empty,
    input logic                       pause,
    input logic                       error,
    input vc_switch_pkg::threshold_t  af_threshold
);

    int fail_count = 0;

    // empty and almost full exclude each other once af is nonzero
    no_empty_pause: assert property (@(posedge clk) disable iff (!reset_L)
        (af_threshold != '0) |-> !(empty && pause))
        else begin
            fail_count++;
            $error("empty and pause high together");
        end

    error_has_cause: assert property (@(posedge clk) disable iff (!reset_L)
        error |-> ((push && full) || (pop && empty)))
        else begin
            fail_count++;
            $error("error high without a push while full or a pop while empty");
        end

endmodule

bind vc_fifo vc_switch_props u_props (
    .clk          (clk),
    .reset_L      (reset_L),
    .push         (push),
    .pop          (pop),
    .full         (full),
    .empty        (empty),
    .pause        (pause),
    .error        (error),
    .af_threshold (af_threshold)
);

//--- source/vc_switch_top.sv
`timescale 1ns/100ps

`include "vc_switch_params.svh"

module vc_switch_top (
    input  logic                        clk,
    input  logic                        reset_L,
    input  logic                        push,
    input  vc_switch_pkg::data_t        data_in,
    input  vc_switch_pkg::threshold_t   af_threshold,
    input  logic                        pop_d0,
    input  logic                        pop_d1,
    output vc_switch_pkg::data_t        data_d0,
    output vc_switch_pkg::data_t        data_d1,
    output logic                        empty_d0,
    output logic                        empty_d1,
    output logic                        pause_in,
    output logic                        error
);

    // input queue to dispatcher
    logic                  in_empty;
    logic                  in_pop;
    logic                  in_error;
    vc_switch_pkg::data_t  in_data;

    // dispatcher to channel queues
    logic                  vc0_push;
    logic                  vc1_push;
    vc_switch_pkg::data_t  vc_data;

    // channel queues to arbiter
    logic                  vc0_empty;
    logic                  vc1_empty;
    logic                  vc0_pause;
    logic                  vc1_pause;
    logic                  vc0_pop;
    logic                  vc1_pop;
    logic                  vc0_error;
    logic                  vc1_error;
    vc_switch_pkg::data_t  vc0_data;
    vc_switch_pkg::data_t  vc1_data;

    // arbiter to destination queues
    logic                  d0_push;
    logic                  d1_push;
    logic                  d0_pause;
    logic                  d1_pause;
    logic                  d0_error;
    logic                  d1_error;
    vc_switch_pkg::data_t  d_data;

    vc_fifo #(.ADDR_BITS(`MAIN_ADDR_BITS)) u_in_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (push),
        .pop          (in_pop),
        .data_in      (data_in),
        .af_threshold (af_threshold),
        .data_out     (in_data),
        .empty        (in_empty),
        .pause        (pause_in),
        .error        (in_error)
    );

    vc_dispatch u_dispatch (
        .clk       (clk),
        .reset_L   (reset_L),
        .in_empty  (in_empty),
        .in_data   (in_data),
        .vc0_pause (vc0_pause),
        .vc1_pause (vc1_pause),
        .in_pop    (in_pop),
        .vc0_push  (vc0_push),
        .vc1_push  (vc1_push),
        .vc_data   (vc_data)
    );

    vc_fifo #(.ADDR_BITS(`VC_ADDR_BITS)) u_vc0_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (vc0_push),
        .pop          (vc0_pop),
        .data_in      (vc_data),
        .af_threshold (af_threshold),
        .data_out     (vc0_data),
        .empty        (vc0_empty),
        .pause        (vc0_pause),
        .error        (vc0_error)
    );

    vc_fifo #(.ADDR_BITS(`VC_ADDR_BITS)) u_vc1_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (vc1_push),
        .pop          (vc1_pop),
        .data_in      (vc_data),
        .af_threshold (af_threshold),
        .data_out     (vc1_data),
        .empty        (vc1_empty),
        .pause        (vc1_pause),
        .error        (vc1_error)
    );

    vc_egress_arbiter u_arbiter (
        .clk       (clk),
        .reset_L   (reset_L),
        .vc0_empty (vc0_empty),
        .vc1_empty (vc1_empty),
        .vc0_data  (vc0_data),
        .vc1_data  (vc1_data),
        .d0_pause  (d0_pause),
        .d1_pause  (d1_pause),
        .vc0_pop   (vc0_pop),
        .vc1_pop   (vc1_pop),
        .d0_push   (d0_push),
        .d1_push   (d1_push),
        .d_data    (d_data)
    );

    vc_fifo #(.ADDR_BITS(`VC_ADDR_BITS)) u_d0_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (d0_push),
        .pop          (pop_d0),
        .data_in      (d_data),
        .af_threshold (af_threshold),
        .data_out     (data_d0),
        .empty        (empty_d0),
        .pause        (d0_pause),
        .error        (d0_error)
    );

    vc_fifo #(.ADDR_BITS(`VC_ADDR_BITS)) u_d1_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .push         (d1_push),
        .pop          (pop_d1),
        .data_in      (d_data),
        .af_threshold (af_threshold),
        .data_out     (data_d1),
        .empty        (empty_d1),
        .pause        (d1_pause),
        .error        (d1_error)
    );

    // any queue misuse shows on the one error pin
    assign error = in_error || vc0_error || vc1_error || d0_error || d1_error;

endmodule

//--- source/vc_egress_arbiter.sv
`timescale 1ns/100ps

`include "vc_switch_params.svh"

module vc_egress_arbiter (
    input  logic                  clk,
    input  logic                  reset_L,
    input  logic                  vc0_empty,
    input  logic                  vc1_empty,
    input  vc_switch_pkg::data_t  vc0_data,
    input  vc_switch_pkg::data_t  vc1_data,
    input  logic                  d0_pause,
    input  logic                  d1_pause,
    output logic                  vc0_pop,
    output logic                  vc1_pop,
    output logic                  d0_push,
    output logic                  d1_push,
    output vc_switch_pkg::data_t  d_data
);

    vc_switch_pkg::arb_state_t state;
    vc_switch_pkg::arb_state_t state_next;
    logic                      sel_vc1;     // channel popped last
    logic                      in_idle;
    logic                      in_deliver;
    logic                      to_d1;

    assign in_idle    = (state == vc_switch_pkg::ARB_IDLE);
    assign in_deliver = (state == vc_switch_pkg::ARB_DELIVER);

    // strict priority, channel 1 only when channel 0 has nothing
    assign vc0_pop = in_idle && !vc0_empty;
    assign vc1_pop = in_idle && vc0_empty && !vc1_empty;

    assign d_data  = sel_vc1 ? vc1_data : vc0_data;
    assign to_d1   = d_data[`DEST_BIT];
    assign d0_push = in_deliver && !to_d1 && !d0_pause;
    assign d1_push = in_deliver && to_d1 && !d1_pause;

    always_comb begin
        state_next = state;
        case (state)
            vc_switch_pkg::ARB_IDLE: begin
                if (vc0_pop || vc1_pop) begin
                    state_next = vc_switch_pkg::ARB_DELIVER;
                end
            end
            vc_switch_pkg::ARB_DELIVER: begin
                if (d0_push || d1_push) begin
                    state_next = vc_switch_pkg::ARB_IDLE;   // else wait out the pause
                end
            end
            default: state_next = vc_switch_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            state   <= vc_switch_pkg::ARB_IDLE;
            sel_vc1 <= 1'b0;
        end else begin
            state <= state_next;
            if (vc0_pop || vc1_pop) begin
                sel_vc1 <= vc1_pop;
            end
        end
    end

endmodule

//--- source/vc_dispatch.sv
`timescale 1ns/100ps

`include "vc_switch_params.svh"

module vc_dispatch (
    input  logic                  clk,
    input  logic                  reset_L,
    input  logic                  in_empty,
    input  vc_switch_pkg::data_t  in_data,
    input  logic                  vc0_pause,
    input  logic                  vc1_pause,
    output logic                  in_pop,
    output logic                  vc0_push,
    output logic                  vc1_push,
    output vc_switch_pkg::data_t  vc_data
);

    logic in_flight;    // word waiting on in_data
    logic to_vc1;
    logic pushed;

    // channel is only known once the word is out of the input fifo
    assign in_pop = !in_empty && !in_flight;

    assign to_vc1   = in_data[`VC_BIT];
    assign vc0_push = in_flight && !to_vc1 && !vc0_pause;
    assign vc1_push = in_flight && to_vc1 && !vc1_pause;
    assign pushed   = vc0_push || vc1_push;

    assign vc_data = in_data;   // input fifo holds it while stalled

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            in_flight <= 1'b0;
        end else if (in_pop) begin
            in_flight <= 1'b1;
        end else if (pushed) begin
            in_flight <= 1'b0;
        end
    end

endmodule

//--- source/vc_fifo.sv
`timescale 1ns/100ps

module vc_fifo #(
    parameter int ADDR_BITS = 3
) (
    input  logic                        clk,
    input  logic                        reset_L,
    input  logic                        push,
    input  logic                        pop,
    input  vc_switch_pkg::data_t        data_in,
    input  vc_switch_pkg::threshold_t   af_threshold,
    output vc_switch_pkg::data_t        data_out,
    output logic                        empty,
    output logic                        pause,
    output logic                        error
);

    localparam vc_switch_pkg::count_t DEPTH = vc_switch_pkg::count_t'(2 ** ADDR_BITS);

    logic [ADDR_BITS-1:0]   wr_ptr;
    logic [ADDR_BITS-1:0]   rd_ptr;
    vc_switch_pkg::count_t  count;
    vc_switch_pkg::data_t   ram_data;
    logic                   full;
    logic                   push_ok;
    logic                   pop_ok;

    fifo_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) u_ram (
        .clk      (clk),
        .write    (push_ok),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (data_in),
        .data_out (ram_data)
    );

    // status straight from the fill level
    assign empty = (count == '0);
    assign full  = (count == DEPTH);
    assign pause = (count >= af_threshold);

    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // pulses only in the offending cycle
    assign error = (push && full) || (pop && empty);

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // output word, loaded on every accepted pop
    always_ff @(posedge clk) begin
        if (pop_ok) begin
            data_out <= ram_data;   // held until the next pop
        end
    end

endmodule

//--- source/fifo_ram.sv
`timescale 1ns/100ps

module fifo_ram #(
    parameter int ADDR_BITS = 3
) (
    input  logic                  clk,
    input  logic                  write,
    input  logic [ADDR_BITS-1:0]  wr_ptr,
    input  logic [ADDR_BITS-1:0]  rd_ptr,
    input  vc_switch_pkg::data_t  data_in,
    output vc_switch_pkg::data_t  data_out
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    vc_switch_pkg::data_t mem [DEPTH];

    // one write port, clocked
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // read is asynchronous, the fifo registers it
    assign data_out = mem[rd_ptr];

endmodule

//--- source/vc_switch_pkg.sv
package vc_switch_pkg;

`include "vc_switch_params.svh"

    typedef logic [`DATA_SIZE-1:0] data_t;

    // fill level of one queue
    typedef logic [`COUNT_BITS-1:0] count_t;

    typedef logic [`COUNT_BITS-1:0] threshold_t;    // almost-full level

    typedef enum logic {
        ARB_IDLE    = 1'b0,
        ARB_DELIVER = 1'b1
    } arb_state_t;

endpackage

//--- include/vc_switch_params.svh
`ifndef VC_SWITCH_PARAMS_SVH
`define VC_SWITCH_PARAMS_SVH

// word layout: [5] virtual channel, [4] destination, [3:0] payload
`define DATA_SIZE 6

// input queue is 16 deep, channel and destination queues 8 deep
`define MAIN_ADDR_BITS 4
`define VC_ADDR_BITS 3

`define VC_BIT 5
`define DEST_BIT 4

// holds 0..16 for the deepest queue
`define COUNT_BITS 5

`endif
